/* dii_pkg.sv */
`default_nettype none

package dii_pkg;

   // Flit format of the debug interconnect.
   localparam int FLIT_WIDTH = 16;

   typedef logic [FLIT_WIDTH-1:0] flit_t;

   // Source ids are ten bits wide.
   localparam int ID_WIDTH = 10;

   // Packet class field in the header.
   localparam int TYPE_WIDTH = 2;
   localparam logic [TYPE_WIDTH-1:0] TYPE_TRACE = 2'd2;

   // Header field positions.
   localparam int HDR_TYPE_MSB     = 15;
   localparam int HDR_OVERFLOW_BIT = 11;
   localparam int HDR_BULK_BIT     = 10;

   // Top bit of an overflow-status flit.
   localparam logic STATUS_MARK = 1'b1;

endpackage

`default_nettype wire

/* trace_pkg.sv */
`default_nettype none

package trace_pkg;

   // Drop counter carried in a status flit, saturating.
   localparam int DROP_WIDTH = 10;

   typedef logic [DROP_WIDTH-1:0] drop_cnt_t;

   // Queue depth.
   typedef logic [7:0] depth_t;

   // Payload flits for an event, rounded up.
   function automatic int flits_for(input int width);
      return (width + dii_pkg::FLIT_WIDTH - 1) / dii_pkg::FLIT_WIDTH;
   endfunction

endpackage

`default_nettype wire

/* trace_event_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module trace_event_queue #(
   parameter type               event_t = logic [31:0],
   parameter trace_pkg::depth_t DEPTH   = 4
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   trace_valid,
   input  event_t trace_data,
   output logic   trace_ready,
   output logic   ev_valid,
   output event_t ev_data,
   output logic   ev_overflow,
   input  logic   ev_ready
);

   import trace_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

   event_t           mem     [DEPTH];
   logic             ovf_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   drop_cnt_t        drop_cnt;
   drop_cnt_t        drop_inc;
   drop_cnt_t        rec_cnt;
   logic             ovf_pending;
   logic             full;
   logic             push;
   logic             push_ovf;
   logic             drop;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == LAST_PTR) ? '0 : p + 1'b1;
   endfunction

   assign full        = (count == FULL_CNT);
   assign trace_ready = !full;
   assign push_ovf    = ovf_pending && !full;
   assign push        = push_ovf || (trace_valid && !full);
   assign drop        = trace_valid && full;
   assign pop         = ev_valid && ev_ready;

   assign drop_inc = (drop_cnt == '1) ? drop_cnt : drop_cnt + 1'b1;
   // An event arriving with the record joins its count.
   assign rec_cnt  = trace_valid ? drop_inc : drop_cnt;

   assign ev_valid    = (count != '0);
   assign ev_data     = mem[rd_ptr];
   assign ev_overflow = ovf_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr]     <= push_ovf ? event_t'(rec_cnt) : trace_data;
         ovf_mem[wr_ptr] <= push_ovf;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         drop_cnt    <= '0;
         ovf_pending <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (!push && pop) begin
            count <= count - 1'b1;
         end
         if (push_ovf) begin
            drop_cnt    <= '0;
            ovf_pending <= 1'b0;
         end else if (drop) begin
            drop_cnt    <= drop_inc;
            ovf_pending <= 1'b1;
         end
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= FULL_CNT);

endmodule

`default_nettype wire

/* trace_packetizer.sv */
`timescale 1ns/1ns
`default_nettype none

module trace_packetizer #(
   parameter int WIDTH = 32
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [dii_pkg::ID_WIDTH-1:0]  id,
   input  logic [dii_pkg::FLIT_WIDTH-1:0] dest,
   input  logic                          ev_valid,
   input  logic [WIDTH-1:0]              ev_data,
   input  logic                          ev_overflow,
   output logic                          ev_ready,
   output logic                          flit_valid,
   output logic [dii_pkg::FLIT_WIDTH-1:0] flit_data,
   output logic                          flit_last,
   input  logic                          flit_ready
);

   import dii_pkg::*;
   import trace_pkg::*;

   localparam int NUM_FLITS = flits_for(WIDTH);
   localparam int CNT_W     = (NUM_FLITS > 1) ? $clog2(NUM_FLITS) : 1;
   localparam int PAD_W     = NUM_FLITS * FLIT_WIDTH;

   typedef enum logic [1:0] {
      S_DEST,
      S_HDR,
      S_STATUS,
      S_PAYLOAD
   } state_t;

   state_t           state;
   state_t           state_nxt;
   logic [CNT_W-1:0] cnt;
   logic [CNT_W-1:0] cnt_nxt;
   logic             last_payload;
   logic [PAD_W-1:0] payload;
   flit_t            hdr_flit;
   flit_t            status_flit;

   // Zero-filled above the event width.
   assign payload      = PAD_W'(ev_data);
   assign last_payload = (cnt == CNT_W'(NUM_FLITS - 1));
   assign status_flit  = {STATUS_MARK, {(FLIT_WIDTH - 1 - DROP_WIDTH){1'b0}},
                          ev_data[DROP_WIDTH-1:0]};

   always_comb begin
      hdr_flit                                = '0;
      hdr_flit[HDR_TYPE_MSB -: TYPE_WIDTH]    = TYPE_TRACE;
      hdr_flit[HDR_OVERFLOW_BIT]              = ev_overflow;
      hdr_flit[HDR_BULK_BIT]                  = 1'b0;
      hdr_flit[ID_WIDTH-1:0]                  = id;
   end

   always_comb begin
      state_nxt  = state;
      cnt_nxt    = cnt;
      flit_valid = 1'b1;
      flit_data  = '0;
      flit_last  = 1'b0;
      case (state)
         S_DEST: begin
            flit_valid = ev_valid;
            flit_data  = dest;
            if (ev_valid && flit_ready) begin
               state_nxt = S_HDR;
            end
         end
         S_HDR: begin
            flit_data = hdr_flit;
            cnt_nxt   = '0;
            if (flit_ready) begin
               state_nxt = ev_overflow ? S_STATUS : S_PAYLOAD;
            end
         end
         S_STATUS: begin
            flit_data = status_flit;
            flit_last = 1'b1;
            if (flit_ready) begin
               state_nxt = S_DEST;
            end
         end
         S_PAYLOAD: begin
            // Least significant flit first.
            flit_data = payload[int'(cnt) * FLIT_WIDTH +: FLIT_WIDTH];
            flit_last = last_payload;
            if (flit_ready) begin
               if (last_payload) begin
                  state_nxt = S_DEST;
               end else begin
                  cnt_nxt = cnt + 1'b1;
               end
            end
         end
         default: state_nxt = S_DEST;
      endcase
   end

   // Queue item retires with the final flit.
   assign ev_ready = flit_valid && flit_ready && flit_last;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_DEST;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         cnt   <= cnt_nxt;
      end
   end

   // Last flit matches the kind of the queue item still on offer.
   a_last_pos: assert property (@(posedge clk) disable iff (rst)
      flit_last |-> ev_valid && (ev_overflow ? (state == S_STATUS)
                                             : (state == S_PAYLOAD && last_payload)));

   // Relies on the queue holding its item until ev_ready.
   a_flit_hold: assert property (@(posedge clk) disable iff (rst)
      flit_valid && !flit_ready |=> flit_valid && $stable(flit_data));

endmodule

`default_nettype wire

/* packet_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_arbiter (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req_valid_a,
   input  logic [dii_pkg::FLIT_WIDTH-1:0] req_data_a,
   input  logic                           req_last_a,
   output logic                           req_ready_a,
   input  logic                           req_valid_b,
   input  logic [dii_pkg::FLIT_WIDTH-1:0] req_data_b,
   input  logic                           req_last_b,
   output logic                           req_ready_b,
   output logic                           out_valid,
   output logic [dii_pkg::FLIT_WIDTH-1:0] out_data,
   output logic                           out_last,
   input  logic                           out_ready
);

   // Grant of 1 selects channel b.
   logic grant;
   logic lock;
   logic sel;
   logic accept;

   // Round robin on a tie, otherwise whoever requests.
   always_comb begin
      if (lock) begin
         sel = grant;
      end else if (req_valid_a && req_valid_b) begin
         sel = !grant;
      end else begin
         sel = req_valid_b;
      end
   end

   assign out_valid   = sel ? req_valid_b : req_valid_a;
   assign out_data    = sel ? req_data_b : req_data_a;
   assign out_last    = sel ? req_last_b : req_last_a;
   assign req_ready_a = out_ready && !sel;
   assign req_ready_b = out_ready && sel;
   assign accept      = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         grant <= 1'b1;
         lock  <= 1'b0;
      end else if (accept) begin
         grant <= sel;
         lock  <= !out_last;
      end
   end

   // The locked grant points at a packet that streams without gaps.
   a_grant_locked: assert property (@(posedge clk) disable iff (rst)
      lock |-> out_valid);

endmodule

`default_nettype wire

/* debug_credit_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module debug_credit_tx #(
   parameter int CREDITS = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           in_valid,
   input  logic [dii_pkg::FLIT_WIDTH-1:0] in_data,
   input  logic                           in_last,
   output logic                           in_ready,
   output logic                           link_valid,
   output logic [dii_pkg::FLIT_WIDTH-1:0] link_data,
   output logic                           link_last,
   input  logic                           link_credit
);

   localparam int CNT_W = $clog2(CREDITS + 1);
   localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(CREDITS);

   logic [CNT_W-1:0] credits;
   logic             send;

   // The output register drains every cycle, so only credits gate input.
   assign in_ready = (credits != '0);
   assign send     = in_valid && in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         credits    <= MAX_CREDITS;
         link_valid <= 1'b0;
      end else begin
         link_valid <= send;
         case ({send, link_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (send) begin
         link_data <= in_data;
         link_last <= in_last;
      end
   end

   // Receiver never returns more credits than flits it got.
   a_credit_bound: assert property (@(posedge clk) disable iff (rst)
      credits <= MAX_CREDITS);

endmodule

`default_nettype wire

/* trace_subsystem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module trace_subsystem_top #(
   parameter int                WIDTH_A      = 32,
   parameter int                WIDTH_B      = 40,
   parameter trace_pkg::depth_t QUEUE_DEPTH  = 4,
   parameter int                LINK_CREDITS = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [dii_pkg::FLIT_WIDTH-1:0] dest,
   input  logic [dii_pkg::ID_WIDTH-1:0]   id_a,
   input  logic [dii_pkg::ID_WIDTH-1:0]   id_b,
   input  logic                           trace_valid_a,
   input  logic [WIDTH_A-1:0]             trace_data_a,
   output logic                           trace_ready_a,
   input  logic                           trace_valid_b,
   input  logic [WIDTH_B-1:0]             trace_data_b,
   output logic                           trace_ready_b,
   output logic                           link_valid,
   output logic [dii_pkg::FLIT_WIDTH-1:0] link_data,
   output logic                           link_last,
   input  logic                           link_credit
);

   import dii_pkg::*;

   logic               ev_valid_a;
   logic [WIDTH_A-1:0] ev_data_a;
   logic               ev_overflow_a;
   logic               ev_ready_a;
   logic               ev_valid_b;
   logic [WIDTH_B-1:0] ev_data_b;
   logic               ev_overflow_b;
   logic               ev_ready_b;

   logic  flit_valid_a;
   flit_t flit_data_a;
   logic  flit_last_a;
   logic  flit_ready_a;
   logic  flit_valid_b;
   flit_t flit_data_b;
   logic  flit_last_b;
   logic  flit_ready_b;

   logic  arb_valid;
   flit_t arb_data;
   logic  arb_last;
   logic  arb_ready;

   trace_event_queue #(
      .event_t (logic [WIDTH_A-1:0]),
      .DEPTH   (QUEUE_DEPTH)
   ) i_queue_a (
      .clk         (clk),
      .rst         (rst),
      .trace_valid (trace_valid_a),
      .trace_data  (trace_data_a),
      .trace_ready (trace_ready_a),
      .ev_valid    (ev_valid_a),
      .ev_data     (ev_data_a),
      .ev_overflow (ev_overflow_a),
      .ev_ready    (ev_ready_a)
   );

   trace_event_queue #(
      .event_t (logic [WIDTH_B-1:0]),
      .DEPTH   (QUEUE_DEPTH)
   ) i_queue_b (
      .clk         (clk),
      .rst         (rst),
      .trace_valid (trace_valid_b),
      .trace_data  (trace_data_b),
      .trace_ready (trace_ready_b),
      .ev_valid    (ev_valid_b),
      .ev_data     (ev_data_b),
      .ev_overflow (ev_overflow_b),
      .ev_ready    (ev_ready_b)
   );

   trace_packetizer #(
      .WIDTH (WIDTH_A)
   ) i_packetizer_a (
      .clk         (clk),
      .rst         (rst),
      .id          (id_a),
      .dest        (dest),
      .ev_valid    (ev_valid_a),
      .ev_data     (ev_data_a),
      .ev_overflow (ev_overflow_a),
      .ev_ready    (ev_ready_a),
      .flit_valid  (flit_valid_a),
      .flit_data   (flit_data_a),
      .flit_last   (flit_last_a),
      .flit_ready  (flit_ready_a)
   );

   trace_packetizer #(
      .WIDTH (WIDTH_B)
   ) i_packetizer_b (
      .clk         (clk),
      .rst         (rst),
      .id          (id_b),
      .dest        (dest),
      .ev_valid    (ev_valid_b),
      .ev_data     (ev_data_b),
      .ev_overflow (ev_overflow_b),
      .ev_ready    (ev_ready_b),
      .flit_valid  (flit_valid_b),
      .flit_data   (flit_data_b),
      .flit_last   (flit_last_b),
      .flit_ready  (flit_ready_b)
   );

   packet_arbiter i_arbiter (
      .clk         (clk),
      .rst         (rst),
      .req_valid_a (flit_valid_a),
      .req_data_a  (flit_data_a),
      .req_last_a  (flit_last_a),
      .req_ready_a (flit_ready_a),
      .req_valid_b (flit_valid_b),
      .req_data_b  (flit_data_b),
      .req_last_b  (flit_last_b),
      .req_ready_b (flit_ready_b),
      .out_valid   (arb_valid),
      .out_data    (arb_data),
      .out_last    (arb_last),
      .out_ready   (arb_ready)
   );

   debug_credit_tx #(
      .CREDITS (LINK_CREDITS)
   ) i_credit_tx (
      .clk         (clk),
      .rst         (rst),
      .in_valid    (arb_valid),
      .in_data     (arb_data),
      .in_last     (arb_last),
      .in_ready    (arb_ready),
      .link_valid  (link_valid),
      .link_data   (link_data),
      .link_last   (link_last),
      .link_credit (link_credit)
   );

endmodule

`default_nettype wire

/* tb_trace_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_trace_subsystem;

   import dii_pkg::*;
   import trace_pkg::*;

   localparam int WIDTH_A       = 32;
   localparam int WIDTH_B       = 40;
   localparam int QUEUE_DEPTH   = 4;
   localparam int LINK_CREDITS  = 4;
   localparam int NFLITS_A      = (WIDTH_A + 15) / 16;
   localparam int NFLITS_B      = (WIDTH_B + 15) / 16;
   localparam int MAX_PKT_FLITS = 2 + ((NFLITS_A > NFLITS_B) ? NFLITS_A : NFLITS_B);
   localparam int N_EVENTS      = 200;
   localparam int RATE          = 3;
   localparam int HOLD_START    = 300;
   localparam int HOLD_END      = 600;
   localparam int DRAIN_IDLE    = 100;
   localparam int STALL_FACTOR  = 8;
   localparam int TIMEOUT_CYCLES = 2 * N_EVENTS * MAX_PKT_FLITS * STALL_FACTOR;

   logic               clk;
   logic               rst;
   logic [15:0]        dest;
   logic [9:0]         id_a;
   logic [9:0]         id_b;
   logic               trace_valid_a;
   logic [WIDTH_A-1:0] trace_data_a;
   logic               trace_ready_a;
   logic               trace_valid_b;
   logic [WIDTH_B-1:0] trace_data_b;
   logic               trace_ready_b;
   logic               link_valid;
   logic [15:0]        link_data;
   logic               link_last;
   logic               link_credit;

   integer      seed;
   int          errors;
   int          cycle;
   int          packets;
   int          rx_flits;
   int          credits_returned;
   int          idle_cycles;
   logic [15:0] pkt [$];
   logic [63:0] sent_a [$];
   logic [63:0] sent_b [$];
   int          next_seq [2];
   int          pending [2];
   int          delivered [2];
   int          drops [2];
   int          records [2];

   trace_subsystem_top #(
      .WIDTH_A      (WIDTH_A),
      .WIDTH_B      (WIDTH_B),
      .QUEUE_DEPTH  (QUEUE_DEPTH),
      .LINK_CREDITS (LINK_CREDITS)
   ) i_trace_subsystem_top (
      .clk           (clk),
      .rst           (rst),
      .dest          (dest),
      .id_a          (id_a),
      .id_b          (id_b),
      .trace_valid_a (trace_valid_a),
      .trace_data_a  (trace_data_a),
      .trace_ready_a (trace_ready_a),
      .trace_valid_b (trace_valid_b),
      .trace_data_b  (trace_data_b),
      .trace_ready_b (trace_ready_b),
      .link_valid    (link_valid),
      .link_data     (link_data),
      .link_last     (link_last),
      .link_credit   (link_credit)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
   endtask

   function automatic logic [63:0] sent_event(input int ch, input int idx);
      return ch ? sent_b[idx] : sent_a[idx];
   endfunction

   function automatic bit accounted(input int ch);
      return delivered[ch] + drops[ch] == (ch ? sent_b.size() : sent_a.size());
   endfunction

   // Header, length and body of one reassembled packet.
   task automatic check_packet();
      int          ch;
      int          i;
      int          idx;
      int          nflits;
      int          width;
      int          exp_len;
      logic        ovf;
      logic [15:0] hdr;
      logic [15:0] exp_hdr;
      logic [15:0] status;
      logic [63:0] val;
      if (pkt.size() < 3) begin
         report_error("packet shorter than three flits");
         return;
      end
      check_value("dest flit", 64'(dest), 64'(pkt[0]));
      hdr = pkt[1];
      ovf = hdr[HDR_OVERFLOW_BIT];
      if (hdr[9:0] == id_a) begin
         ch = 0;
      end else if (hdr[9:0] == id_b) begin
         ch = 1;
      end else begin
         report_error("header carries an unknown source id");
         return;
      end
      exp_hdr                            = '0;
      exp_hdr[HDR_TYPE_MSB -: 2]         = TYPE_TRACE;
      exp_hdr[HDR_OVERFLOW_BIT]          = ovf;
      exp_hdr[ID_WIDTH-1:0]              = ch ? id_b : id_a;
      check_value("header", 64'(exp_hdr), 64'(hdr));
      nflits  = ch ? NFLITS_B : NFLITS_A;
      width   = ch ? WIDTH_B : WIDTH_A;
      exp_len = ovf ? 3 : 2 + nflits;
      check_value("packet length", 64'(exp_len), 64'(pkt.size()));
      if (pkt.size() != exp_len) begin
         return;
      end
      if (ovf) begin
         status = pkt[2];
         check_value("status mark", 64'h8000, 64'(status & 16'hfc00));
         // Drops add up until the next event closes the gap.
         pending[ch] += int'(status[DROP_WIDTH-1:0]);
         drops[ch]   += int'(status[DROP_WIDTH-1:0]);
         records[ch]++;
      end else begin
         val = '0;
         for (i = 0; i < nflits; i++) begin
            val[i*16 +: 16] = pkt[2+i];
         end
         check_value("payload padding", 64'h0, val >> width);
         idx = next_seq[ch] + pending[ch];
         if (idx >= (ch ? sent_b.size() : sent_a.size())) begin
            report_error("event delivered beyond the events sent");
         end else begin
            check_value(ch ? "payload b" : "payload a", sent_event(ch, idx), val);
            next_seq[ch] = idx + 1;
            pending[ch]  = 0;
            delivered[ch]++;
         end
      end
   endtask

   // Link receiver.
   always @(negedge clk) begin
      if (link_valid === 1'b1) begin
         idle_cycles = 0;
         rx_flits++;
         if (rx_flits - credits_returned > LINK_CREDITS) begin
            report_error("more flits outstanding than link credits");
         end
         pkt.push_back(link_data);
         if (link_last) begin
            check_packet();
            packets++;
            pkt.delete();
         end else if (pkt.size() > MAX_PKT_FLITS) begin
            report_error("packet runs past its length without link_last");
            pkt.delete();
         end
      end else begin
         idle_cycles++;
      end
   end

   // One cycle of trace traffic and credit returns.
   task automatic drive_cycle(input bit sending);
      logic [63:0] data64;
      bit          hold;
      @(posedge clk);
      #1;
      cycle++;
      trace_valid_a = 1'b0;
      trace_valid_b = 1'b0;
      if (sending && sent_a.size() < N_EVENTS && ($random(seed) & 15) < RATE) begin
         data64        = {$random(seed), $random(seed)};
         trace_valid_a = 1'b1;
         trace_data_a  = data64[WIDTH_A-1:0];
         sent_a.push_back(64'(trace_data_a));
      end
      if (sending && sent_b.size() < N_EVENTS && ($random(seed) & 15) < RATE) begin
         data64        = {$random(seed), $random(seed)};
         trace_valid_b = 1'b1;
         trace_data_b  = data64[WIDTH_B-1:0];
         sent_b.push_back(64'(trace_data_b));
      end
      hold        = (cycle >= HOLD_START) && (cycle < HOLD_END);
      if (cycle == HOLD_END) begin
         // A long stall uses up every credit and fills both queues.
         check_value("outstanding flits after hold", 64'(LINK_CREDITS),
                     64'(rx_flits - credits_returned));
         check_value("trace_ready_a after hold", 64'h0, 64'(trace_ready_a));
         check_value("trace_ready_b after hold", 64'h0, 64'(trace_ready_b));
      end
      link_credit = 1'b0;
      if (!hold && rx_flits > credits_returned && ($random(seed) & 3) != 0) begin
         link_credit = 1'b1;
         credits_returned++;
      end
   endtask

   initial begin
      seed          = 32'h90e7;
      rst           = 1'b1;
      dest          = 16'hd0c3;
      id_a          = 10'h2a5;
      id_b          = 10'h15a;
      trace_valid_a = 1'b0;
      trace_data_a  = '0;
      trace_valid_b = 1'b0;
      trace_data_b  = '0;
      link_credit   = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      check_value("trace_ready_a after reset", 64'h1, 64'(trace_ready_a));
      check_value("trace_ready_b after reset", 64'h1, 64'(trace_ready_b));
      check_value("link_valid after reset", 64'h0, 64'(link_valid));
      while (sent_a.size() < N_EVENTS || sent_b.size() < N_EVENTS) begin
         drive_cycle(1'b1);
      end
      while (!(accounted(0) && accounted(1)) && idle_cycles < DRAIN_IDLE) begin
         drive_cycle(1'b0);
      end
      check_value("accounting a", 64'(sent_a.size()), 64'(delivered[0] + drops[0]));
      check_value("accounting b", 64'(sent_b.size()), 64'(delivered[1] + drops[1]));
      if (records[0] == 0) begin
         report_error("no overflow record seen on channel a");
      end
      if (records[1] == 0) begin
         report_error("no overflow record seen on channel b");
      end
      if (pkt.size() != 0) begin
         report_error("link went quiet inside a packet");
      end
      $display("Packets %0d, a %0d delivered %0d dropped, b %0d delivered %0d dropped, errors %0d",
               packets, delivered[0], drops[0], delivered[1], drops[1], errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
dii_pkg.sv
trace_pkg.sv
trace_event_queue.sv
trace_packetizer.sv
packet_arbiter.sv
debug_credit_tx.sv
trace_subsystem_top.sv
tb_trace_subsystem.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_trace_subsystem
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation completed successfully

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
